// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame writer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f \
  --top-module tb_frame_writer -o sim_frame_writer

./obj_dir/sim_frame_writer | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run finished, see sim.log"

// ==== src/chunk_fifo.sv ====
`timescale 1ns/1ns

module chunk_fifo import frame_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic    clk_camera,
  input  logic    recent_reset,
  chunk_if.sink   chunk_i,
  chunk_if.source chunk_o
);

  // pointer width, depth is a power of two so pointers wrap by themselves
  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [AW:0] FULL_COUNT = (AW + 1)'(FIFO_DEPTH);

  // slot storage
  chunk_data_t data_mem [FIFO_DEPTH];
  logic        last_mem [FIFO_DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full  = (count == FULL_COUNT);
  assign empty = (count == '0);

  // a full FIFO still accepts when the head leaves on the same edge
  assign chunk_i.ready = !full || chunk_o.ready;
  assign chunk_o.valid = !empty;

  assign push = chunk_i.valid && chunk_i.ready;
  assign pop  = chunk_o.valid && chunk_o.ready;

  // head of queue, visible right after the push edge
  assign chunk_o.data       = data_mem[rd_ptr];
  assign chunk_o.frame_last = last_mem[rd_ptr];

  // slot write
  always_ff @(posedge clk_camera) begin
    if (push) begin
      data_mem[wr_ptr] <= chunk_i.data;
      last_mem[wr_ptr] <= chunk_i.frame_last;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // overflow, a write lands on the head slot only while nothing is stored
  a_no_overflow: assert property (
    @(posedge clk_camera) disable iff (recent_reset)
    push && !pop |-> (wr_ptr != rd_ptr) || empty
  );

  // underflow, pointers must disagree or wrap fully when popping
  a_no_underflow: assert property (
    @(posedge clk_camera) disable iff (recent_reset)
    pop |-> (rd_ptr != wr_ptr) || full
  );

endmodule

// ==== src/chunk_if.sv ====
`timescale 1ns/1ns

// chunk stream with ready/valid flow control
// transfer on a rising edge where valid and ready are both high
interface chunk_if import frame_pkg::*; ();

  // eight packed pixels
  chunk_data_t data;

  // marks the final chunk of a frame
  logic frame_last;

  // source side handshake
  logic valid;

  // sink side handshake
  logic ready;

  // producer view, holds data until accepted
  modport source (
    output data,
    output frame_last,
    output valid,
    input  ready
  );

  // consumer view
  modport sink (
    input  data,
    input  frame_last,
    input  valid,
    output ready
  );

endinterface

// ==== src/chunk_writer.sv ====
`timescale 1ns/1ns

module chunk_writer import frame_pkg::*; (
  input  logic        clk_camera,
  input  logic        recent_reset,
  chunk_if.sink       chunk_i,
  input  logic        mem_ready_i,
  output logic        mem_valid_o,
  output chunk_addr_t mem_addr_o,
  output chunk_data_t mem_data_o,
  output logic        mem_last_o
);

  logic take;
  logic mem_done;

  // register empty, or memory takes it this edge
  assign chunk_i.ready = !mem_valid_o || mem_ready_i;
  assign take          = chunk_i.valid && chunk_i.ready;

  // completed memory beat
  assign mem_done = mem_valid_o && mem_ready_i;

  // output register handshake
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      mem_valid_o <= 1'b0;
      mem_last_o  <= 1'b0;
    end else if (take) begin
      mem_valid_o <= 1'b1;
      mem_last_o  <= chunk_i.frame_last;
    end else if (mem_ready_i) begin
      mem_valid_o <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge clk_camera) begin
    if (take) begin
      mem_data_o <= chunk_i.data;
    end
  end

  // chunk address, restarts after the last chunk of a frame
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      mem_addr_o <= '0;
    end else if (mem_done) begin
      mem_addr_o <= mem_last_o ? '0 : mem_addr_o + 1'b1;
    end
  end

  // memory side sees a steady beat while stalled
  a_mem_hold: assert property (
    @(posedge clk_camera) disable iff (recent_reset)
    mem_valid_o && !mem_ready_i |=>
      mem_valid_o && $stable(mem_addr_o) && $stable(mem_data_o)
  );

endmodule

// ==== src/frame_pkg.sv ====
package frame_pkg;

  // pixels packed side by side into one memory chunk
  localparam int PIXELS_PER_CHUNK = 8;

  // 5-6-5 colour, red in the top bits
  localparam int PIXEL_W = 16;

  // full chunk width, one memory beat
  localparam int CHUNK_W = PIXELS_PER_CHUNK * PIXEL_W;

  // width of the memory write-address port
  localparam int CHUNK_ADDR_W = 27;

  // scan coordinate widths, sized for 1280x720
  localparam int X_COORD_W = 11;
  localparam int Y_COORD_W = 10;

  // one pixel
  typedef logic [PIXEL_W-1:0] pixel_t;

  // pixel k of a chunk lives in bits 16k+15 down to 16k
  typedef logic [CHUNK_W-1:0] chunk_data_t;

  // chunk index into the frame buffer
  typedef logic [CHUNK_ADDR_W-1:0] chunk_addr_t;

  // pixel column within a line
  typedef logic [X_COORD_W-1:0] x_coord_t;

  // line within a frame
  typedef logic [Y_COORD_W-1:0] y_coord_t;

  // test pattern selection
  // white is all ones, column and line give a ramp,
  // xor gives the usual checker-like texture
  typedef enum logic [1:0] {
    PAT_WHITE  = 2'd0,
    PAT_COLUMN = 2'd1,
    PAT_LINE   = 2'd2,
    PAT_XOR    = 2'd3
  } pattern_e;

endpackage

// ==== src/frame_writer_top.sv ====
`timescale 1ns/1ns

module frame_writer_top import frame_pkg::*; #(
  parameter int HRES_CHUNKS = 160,
  parameter int VRES_LINES  = 720,
  parameter int FIFO_DEPTH  = 4
) (
  input  logic        clk_camera,
  input  logic        recent_reset,
  input  pattern_e    pattern_sel_i,
  input  logic        mem_ready_i,
  output logic        mem_valid_o,
  output chunk_addr_t mem_addr_o,
  output chunk_data_t mem_data_o,
  output logic        mem_last_o
);

  // scanner to buffer
  chunk_if scan_to_fifo ();

  // buffer to memory writer
  chunk_if fifo_to_writer ();

  // test pattern source, one pixel per clock
  pattern_scan #(
    .HRES_CHUNKS(HRES_CHUNKS),
    .VRES_LINES (VRES_LINES)
  ) scan (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .pattern_sel_i(pattern_sel_i),
    .chunk_o      (scan_to_fifo)
  );

  // absorbs short memory stalls
  chunk_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) fifo (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .chunk_i     (scan_to_fifo),
    .chunk_o     (fifo_to_writer)
  );

  // memory port, 10 cycles after reset for the first beat
  chunk_writer writer (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .chunk_i     (fifo_to_writer),
    .mem_ready_i (mem_ready_i),
    .mem_valid_o (mem_valid_o),
    .mem_addr_o  (mem_addr_o),
    .mem_data_o  (mem_data_o),
    .mem_last_o  (mem_last_o)
  );

endmodule

// ==== src/pattern_scan.sv ====
`timescale 1ns/1ns

module pattern_scan import frame_pkg::*; #(
  parameter int HRES_CHUNKS = 160,
  parameter int VRES_LINES  = 720
) (
  input  logic     clk_camera,
  input  logic     recent_reset,
  input  pattern_e pattern_sel_i,
  chunk_if.source  chunk_o
);

  // counter widths, kept at least one bit wide
  localparam int PW = (PIXELS_PER_CHUNK > 1) ? $clog2(PIXELS_PER_CHUNK) : 1;
  localparam int CW = (HRES_CHUNKS > 1) ? $clog2(HRES_CHUNKS) : 1;
  localparam int LW = (VRES_LINES > 1) ? $clog2(VRES_LINES) : 1;

  // terminal counts
  localparam logic [PW-1:0] LAST_PIX   = PW'(PIXELS_PER_CHUNK - 1);
  localparam logic [CW-1:0] LAST_CHUNK = CW'(HRES_CHUNKS - 1);
  localparam logic [LW-1:0] LAST_LINE  = LW'(VRES_LINES - 1);

  // scan position
  logic [PW-1:0] pix_cnt;
  logic [CW-1:0] chunk_cnt;
  logic [LW-1:0] line_cnt;

  // output slot
  chunk_data_t pack_q;
  logic        valid_q;
  logic        last_q;

  // pattern held for the running frame
  pattern_e frame_pat;
  pattern_e cur_pat;

  logic     advance;
  logic     first_pix;
  logic     end_chunk;
  logic     end_line;
  logic     end_frame;
  x_coord_t column;
  y_coord_t line;
  pixel_t   pixel;

  // slot is free, or frees up on this edge
  assign advance = !valid_q || chunk_o.ready;

  assign first_pix = (pix_cnt == '0) && (chunk_cnt == '0) && (line_cnt == '0);
  assign end_chunk = (pix_cnt == LAST_PIX);
  assign end_line  = end_chunk && (chunk_cnt == LAST_CHUNK);
  assign end_frame = end_line && (line_cnt == LAST_LINE);

  // first pixel of a frame already follows the new selection
  assign cur_pat = first_pix ? pattern_sel_i : frame_pat;

  // column = chunk * 8 + pixel in chunk
  assign column = x_coord_t'(chunk_cnt) * x_coord_t'(PIXELS_PER_CHUNK) + x_coord_t'(pix_cnt);
  assign line   = y_coord_t'(line_cnt);

  // pixel value from the pattern rules
  always_comb begin
    case (cur_pat)
      PAT_COLUMN: pixel = pixel_t'(column);
      PAT_LINE:   pixel = pixel_t'(line);
      PAT_XOR:    pixel = pixel_t'(column) ^ pixel_t'(line);
      default:    pixel = '1;
    endcase
  end

  // counters and handshake state
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pix_cnt   <= '0;
      chunk_cnt <= '0;
      line_cnt  <= '0;
      valid_q   <= 1'b0;
      last_q    <= 1'b0;
      frame_pat <= PAT_WHITE;
    end else if (advance) begin
      // chunk is complete after its eighth pixel
      valid_q <= end_chunk;
      last_q  <= end_frame;
      if (first_pix) begin
        frame_pat <= pattern_sel_i;
      end
      pix_cnt <= end_chunk ? '0 : pix_cnt + 1'b1;
      if (end_chunk) begin
        chunk_cnt <= end_line ? '0 : chunk_cnt + 1'b1;
      end
      if (end_line) begin
        line_cnt <= end_frame ? '0 : line_cnt + 1'b1;
      end
    end
  end

  // shift in from the top so pixel 0 ends up in the low bits
  always_ff @(posedge clk_camera) begin
    if (advance) begin
      pack_q <= {pixel, pack_q[CHUNK_W-1:PIXEL_W]};
    end
  end

  assign chunk_o.data       = pack_q;
  assign chunk_o.frame_last = last_q;
  assign chunk_o.valid      = valid_q;

  // stalled chunk must not move until the FIFO takes it
  a_hold_stalled: assert property (
    @(posedge clk_camera) disable iff (recent_reset)
    valid_q && !chunk_o.ready |=> valid_q && $stable(pack_q) && $stable(last_q)
  );

endmodule

// ==== testbench/frame_testdata.txt ====
white_ready 0 0 1
column_ready 1 0 1
line_ready 2 0 1
xor_ready 3 0 1
two_frames_white 0 0 2
two_frames_xor 3 0 2
switch_four_frames 1 0 4
switch_from_line 2 0 3
stall_white 0 1 1
stall_column 1 1 2
stall_line 2 1 2
stall_xor 3 1 3
stall_long_run 1 1 5
ready_after_stall 2 0 2

// ==== testbench/tb_frame_writer.sv ====
`timescale 1ns/1ns

module tb_frame_writer import frame_pkg::*; ();

  // reduced geometry, 12 chunks per frame
  localparam int HRES_CHUNKS  = 4;
  localparam int VRES_LINES   = 3;
  localparam int FIFO_DEPTH   = 4;
  localparam int FRAME_CHUNKS = HRES_CHUNKS * VRES_LINES;
  localparam int MAX_TESTS    = 32;
  // memory-side chunk of each frame after which the next pattern is selected
  localparam int SWITCH_CHUNK = 2;
  // free-running cycles before reset, a few chunks land in memory
  localparam int RUN_ON_CYCLES = 3 * PIXELS_PER_CHUNK;
  // long enough for a fresh chunk to reach the memory port
  localparam int STALL_CYCLES  = PIXELS_PER_CHUNK + 4;

  logic        clk_camera;
  logic        recent_reset;
  pattern_e    pattern_sel_i;
  logic        mem_ready_i;
  logic        mem_valid_o;
  chunk_addr_t mem_addr_o;
  chunk_data_t mem_data_o;
  logic        mem_last_o;

  // test table, columns are name, pattern, stall mode, frame count
  logic [8*32-1:0] test_name [MAX_TESTS];
  int              test_pat [MAX_TESTS];
  int              test_stall [MAX_TESTS];
  int              test_frames [MAX_TESTS];
  int              num_tests;
  logic            table_loaded;

  int test_errors;
  int tests_passed;
  int tests_failed;

  frame_writer_top #(
    .HRES_CHUNKS(HRES_CHUNKS),
    .VRES_LINES (VRES_LINES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .pattern_sel_i(pattern_sel_i),
    .mem_ready_i  (mem_ready_i),
    .mem_valid_o  (mem_valid_o),
    .mem_addr_o   (mem_addr_o),
    .mem_data_o   (mem_data_o),
    .mem_last_o   (mem_last_o)
  );

  // 40 ns clock
  initial begin
    clk_camera = 1'b0;
    forever #20 clk_camera = ~clk_camera;
  end

  // pixel value from the pattern rules
  function automatic pixel_t expected_pixel(input int pat, input int column, input int line);
    pixel_t px;
    case (pat)
      1:       px = pixel_t'(column);
      2:       px = pixel_t'(line);
      3:       px = pixel_t'(column ^ line);
      default: px = '1;
    endcase
    return px;
  endfunction

  // idx counts chunks within the frame, pixel k in bits 16k+15:16k
  function automatic chunk_data_t expected_chunk(input int pat, input int idx);
    chunk_data_t data;
    int          line;
    int          column;
    data = '0;
    line = idx / HRES_CHUNKS;
    for (int k = 0; k < PIXELS_PER_CHUNK; k++) begin
      column = (idx % HRES_CHUNKS) * PIXELS_PER_CHUNK + k;
      data[16*k +: 16] = expected_pixel(pat, column, line);
    end
    return data;
  endfunction

  // memory ready for the coming cycle, about one stall in four in random mode
  function automatic logic next_ready(input int stall);
    logic rdy;
    if (stall == 0) begin
      rdy = 1'b1;
    end else begin
      rdy = ($urandom % 4) != 0;
    end
    return rdy;
  endfunction

  task automatic report_mismatch(input int t, input string what, input int idx,
                                 input chunk_data_t expected, input chunk_data_t actual);
    $display("ERR %0s %0s chunk %0d expected %0h actual %0h",
             test_name[t], what, idx, expected, actual);
    test_errors++;
  endtask

  // let the next frame run a few chunks into memory, then stall so a beat
  // with a nonzero address is pending, then reset for 2 cycles
  task automatic apply_reset(input int pat);
    @(posedge clk_camera);
    mem_ready_i <= 1'b1;
    repeat (RUN_ON_CYCLES) @(posedge clk_camera);
    mem_ready_i <= 1'b0;
    repeat (STALL_CYCLES) @(posedge clk_camera);
    recent_reset  <= 1'b1;
    pattern_sel_i <= pattern_e'(pat);
    repeat (2) @(posedge clk_camera);
    recent_reset <= 1'b0;
  endtask

  // drive on rising edges, sample on falling edges
  task automatic run_test(input int t);
    int          received;
    int          total;
    int          frame;
    int          pat;
    chunk_addr_t exp_addr;
    chunk_data_t exp_data;
    logic        exp_last;
    logic        stalled;
    logic        switch_now;
    chunk_addr_t held_addr;
    chunk_data_t held_data;
    total       = test_frames[t] * FRAME_CHUNKS;
    received    = 0;
    frame       = 0;
    exp_addr    = '0;
    stalled     = 1'b0;
    test_errors = 0;
    apply_reset(test_pat[t]);
    mem_ready_i <= next_ready(test_stall[t]);
    @(negedge clk_camera);
    assert (!mem_valid_o) else begin
      $display("test %0s: mem_valid_o is high on the first edge after reset", test_name[t]);
      test_errors++;
    end
    while (received < total) begin
      // a stalled beat must not move
      if (stalled) begin
        assert (mem_valid_o && mem_addr_o == held_addr && mem_data_o == held_data) else begin
          $display("test %0s: memory beat changed while mem_ready_i was low", test_name[t]);
          test_errors++;
        end
      end
      switch_now = 1'b0;
      if (mem_valid_o && mem_ready_i) begin
        // frame f runs on the start pattern advanced by f
        frame    = received / FRAME_CHUNKS;
        pat      = (test_pat[t] + frame) % 4;
        exp_data = expected_chunk(pat, received % FRAME_CHUNKS);
        exp_last = (received % FRAME_CHUNKS) == FRAME_CHUNKS - 1;
        assert (mem_data_o == exp_data) else begin
          report_mismatch(t, "data", received, exp_data, mem_data_o);
        end
        assert (mem_addr_o == exp_addr) else begin
          report_mismatch(t, "address", received, chunk_data_t'(exp_addr),
                          chunk_data_t'(mem_addr_o));
        end
        assert (mem_last_o == exp_last) else begin
          report_mismatch(t, "last", received, chunk_data_t'(exp_last),
                          chunk_data_t'(mem_last_o));
        end
        if (received % FRAME_CHUNKS == SWITCH_CHUNK) begin
          switch_now = 1'b1;
        end
        // address counter restarts after the last chunk
        exp_addr = exp_last ? '0 : exp_addr + 1'b1;
        received++;
      end
      stalled   = mem_valid_o && !mem_ready_i;
      held_addr = mem_addr_o;
      held_data = mem_data_o;
      @(posedge clk_camera);
      mem_ready_i <= next_ready(test_stall[t]);
      // new pattern partway through the frame, scanner still on this frame
      if (switch_now) begin
        pattern_sel_i <= pattern_e'((test_pat[t] + frame + 1) % 4);
      end
      @(negedge clk_camera);
    end
  endtask

  // bounds the run by the summed test lengths
  initial begin
    int limit;
    wait (table_loaded);
    limit = 0;
    for (int t = 0; t < num_tests; t++) begin
      limit += test_frames[t] * FRAME_CHUNKS * 8 * 4 + 100;
    end
    repeat (limit) @(posedge clk_camera);
    $display("timeout: tests did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int   fd;
    int   code;
    logic done;
    recent_reset  = 1'b1;
    mem_ready_i   = 1'b0;
    pattern_sel_i = PAT_WHITE;
    table_loaded  = 1'b0;
    num_tests     = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    test_errors   = 0;
    done          = 1'b0;
    void'($urandom(48582));
    fd = $fopen("testbench/frame_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/frame_testdata.txt");
      $display("Simulation failed");
      $finish;
    end else begin
      while (!done && num_tests < MAX_TESTS && !$feof(fd)) begin
        code = $fscanf(fd, "%s %d %d %d\n", test_name[num_tests], test_pat[num_tests],
                       test_stall[num_tests], test_frames[num_tests]);
        if (code == 4) begin
          num_tests++;
        end else begin
          done = 1'b1;
        end
      end
      $fclose(fd);
      table_loaded = 1'b1;
      for (int t = 0; t < num_tests; t++) begin
        run_test(t);
        if (test_errors == 0) begin
          tests_passed++;
          $display("test %0s ok, %0d chunks checked", test_name[t],
                   test_frames[t] * FRAME_CHUNKS);
        end else begin
          tests_failed++;
          $display("test %0s FAILED with %0d errors", test_name[t], test_errors);
        end
      end
      if (num_tests == 0) begin
        $display("no tests were read from the data file");
      end
      $display("tests run %0d, passed %0d, failed %0d", num_tests, tests_passed, tests_failed);
      if (tests_failed == 0 && num_tests > 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
src/frame_pkg.sv
src/chunk_if.sv
src/pattern_scan.sv
src/chunk_fifo.sv
src/chunk_writer.sv
src/frame_writer_top.sv
testbench/tb_frame_writer.sv
